// File: hdl/fpga_pkg.sv
// ========================================
// Shared constants and enums for the switch
// RESP_DEPTH must be a power of two
// ========================================
`default_nettype none

package fpga_pkg;

    // Channel layout, 2 cages of 4 lanes
    localparam int QSFP_CNT = 2;
    localparam int CH_CNT   = QSFP_CNT * 4;
    localparam int CH_W     = 3;

    // XGMII bus widths and idle fill
    localparam int XGMII_DW = 64;
    localparam int XGMII_CW = 8;
    localparam logic [XGMII_DW-1:0] XGMII_IDLE_D = {8{8'h07}};
    localparam logic [XGMII_CW-1:0] XGMII_IDLE_C = 8'hff;

    // Route entry is {enable, source[2:0]}
    localparam int ROUTE_W = 4;

    // UART bit timing, short for simulation
    localparam int CLKS_PER_BIT = 8;
    localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BAUD_CNT_W-1:0] BAUD_HALF = BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // Response queue and credits
    localparam int RESP_DEPTH = 4;
    localparam int RESP_PTR_W = $clog2(RESP_DEPTH);
    localparam int RESP_CNT_W = $clog2(RESP_DEPTH + 1);
    localparam logic [RESP_CNT_W-1:0] RESP_CREDITS = RESP_CNT_W'(RESP_DEPTH);

    localparam int RST_STAGES = 4;

    typedef enum logic [7:0] {
        OP_SET_ROUTE = 8'h01,
        OP_GET_ROUTE = 8'h02,
        OP_GET_LOCK  = 8'h03
    } cmd_op_t;

    localparam logic [7:0] RESP_ACK = 8'haa;
    localparam logic [7:0] RESP_ERR = 8'hee;

    typedef enum logic [1:0] {
        ST_OP,
        ST_ARG,
        ST_RESP
    } parser_state_t;

endpackage

`default_nettype wire

// File: hdl/sync_reset.sv
// ========================================
// Holds internal reset for RST_STAGES clocks
// Board reset is sampled on clk only
// ========================================
`timescale 1ns/1ns
`default_nettype none

module sync_reset (
    input  logic clk,
    input  logic rst_n,
    output logic rst_sync_n
);

    logic [fpga_pkg::RST_STAGES-1:0] sync_q;

    // Ones shift in after release, last stage is the reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[fpga_pkg::RST_STAGES-2:0], 1'b1};
        end
    end

    assign rst_sync_n = sync_q[fpga_pkg::RST_STAGES-1];

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
// ========================================
// 8N1 receiver, no parity, no back-pressure
// A byte with a bad stop bit is dropped
// ========================================
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                       state_q;
    logic                            rxd_meta;
    logic                            rxd_sync;
    logic                            rxd_prev;
    logic [fpga_pkg::BAUD_CNT_W-1:0] baud_cnt;
    logic [2:0]                      bit_idx;
    logic [7:0]                      shift_q;

    // Two-flop synchronizer plus edge history, idle high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= RX_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit half a bit in
                    if (baud_cnt == fpga_pkg::BAUD_HALF) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state_q  <= rxd_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == fpga_pkg::BAUD_LAST) begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: begin
                    if (baud_cnt == fpga_pkg::BAUD_LAST) begin
                        rx_valid <= rxd_sync;
                        state_q  <= RX_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && baud_cnt == fpga_pkg::BAUD_LAST) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

    // Stays stable until the next frame's data bits
    assign rx_data = shift_q;

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
// ========================================
// 8N1 transmitter behind a RESP_DEPTH queue
// Writer must hold a credit for every byte
// ========================================
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_credit,
    output logic       txd
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    logic [7:0]                      queue_mem [fpga_pkg::RESP_DEPTH];
    logic [fpga_pkg::RESP_PTR_W-1:0] wr_ptr;
    logic [fpga_pkg::RESP_PTR_W-1:0] rd_ptr;
    logic [fpga_pkg::RESP_CNT_W-1:0] queue_cnt;
    logic                            queue_full;
    logic                            push;
    logic                            pop;

    tx_state_t                       state_q;
    logic [fpga_pkg::BAUD_CNT_W-1:0] baud_cnt;
    logic [3:0]                      bit_cnt;
    logic [9:0]                      shift_q;

    assign queue_full = (queue_cnt == fpga_pkg::RESP_CREDITS);
    assign push       = tx_valid && !queue_full;
    assign pop        = (state_q == TX_IDLE) && (queue_cnt != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            queue_mem[wr_ptr] <= tx_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            queue_cnt <= '0;
            tx_credit <= 1'b0;
        end else begin
            tx_credit <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   queue_cnt <= queue_cnt + 1'b1;
                2'b01:   queue_cnt <= queue_cnt - 1'b1;
                default: queue_cnt <= queue_cnt;
            endcase
        end
    end

    // Frame is {stop, data, start}, ones shift in behind it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shift_q  <= '1;
        end else if (state_q == TX_IDLE) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (pop) begin
                shift_q <= {1'b1, queue_mem[rd_ptr], 1'b0};
                state_q <= TX_SEND;
            end
        end else if (baud_cnt == fpga_pkg::BAUD_LAST) begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            shift_q  <= {1'b1, shift_q[9:1]};
            if (bit_cnt == 4'd9) begin
                state_q <= TX_IDLE;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign txd = shift_q[0];

    // Parser credit accounting must keep the queue from overflowing
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n) tx_valid |-> !queue_full
    );

endmodule

`default_nettype wire

// File: hdl/cmd_parser.sv
// ========================================
// Byte command decoder, one response each
// Bytes arriving while a response waits
// for a credit are lost
// ========================================
`timescale 1ns/1ns
`default_nettype none

module cmd_parser (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [7:0]                    rx_data,
    input  logic                          rx_valid,
    output logic [7:0]                    tx_data,
    output logic                          tx_valid,
    input  logic                          tx_credit,
    input  logic [fpga_pkg::CH_CNT-1:0]   rx_block_lock,
    output logic                          route_we,
    output logic [fpga_pkg::CH_W-1:0]     route_dest,
    output logic [fpga_pkg::ROUTE_W-1:0]  route_entry,
    output logic [fpga_pkg::CH_W-1:0]     route_rd_dest,
    input  logic [fpga_pkg::ROUTE_W-1:0]  route_rd_entry
);

    fpga_pkg::parser_state_t         state_q;
    fpga_pkg::cmd_op_t               op_q;
    logic [7:0]                      resp_q;
    logic [fpga_pkg::RESP_CNT_W-1:0] credit_q;

    // Get-route reads the table straight from the argument byte
    assign route_rd_dest = rx_data[fpga_pkg::CH_W-1:0];

    assign tx_valid = (state_q == fpga_pkg::ST_RESP) && (credit_q != '0);
    assign tx_data  = resp_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q  <= fpga_pkg::ST_OP;
            route_we <= 1'b0;
        end else begin
            route_we <= 1'b0;
            case (state_q)
                fpga_pkg::ST_OP: begin
                    if (rx_valid) begin
                        case (rx_data)
                            fpga_pkg::OP_SET_ROUTE, fpga_pkg::OP_GET_ROUTE: begin
                                state_q <= fpga_pkg::ST_ARG;
                            end
                            default: begin
                                state_q <= fpga_pkg::ST_RESP;
                            end
                        endcase
                    end
                end
                fpga_pkg::ST_ARG: begin
                    if (rx_valid) begin
                        route_we <= (op_q == fpga_pkg::OP_SET_ROUTE);
                        state_q  <= fpga_pkg::ST_RESP;
                    end
                end
                default: begin
                    if (tx_valid) begin
                        state_q <= fpga_pkg::ST_OP;
                    end
                end
            endcase
        end
    end

    // Opcode, response and route write fields
    always_ff @(posedge clk) begin
        if (rx_valid && state_q == fpga_pkg::ST_OP) begin
            op_q <= fpga_pkg::cmd_op_t'(rx_data);
            if (rx_data == fpga_pkg::OP_GET_LOCK) begin
                resp_q <= rx_block_lock;
            end else begin
                resp_q <= fpga_pkg::RESP_ERR;
            end
        end else if (rx_valid && state_q == fpga_pkg::ST_ARG) begin
            route_dest  <= rx_data[6:4];
            route_entry <= rx_data[3:0];
            if (op_q == fpga_pkg::OP_SET_ROUTE) begin
                resp_q <= fpga_pkg::RESP_ACK;
            end else begin
                resp_q <= {4'b0000, route_rd_entry};
            end
        end
    end

    // One credit per free slot in the transmitter queue
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q <= fpga_pkg::RESP_CREDITS;
        end else begin
            case ({tx_credit, tx_valid})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n) credit_q <= fpga_pkg::RESP_CREDITS
    );

    // Host sent a byte before the previous response got a credit
    a_no_rx_in_resp: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q == fpga_pkg::ST_RESP) |-> !rx_valid
    );

endmodule

`default_nettype wire

// File: hdl/xgmii_switch.sv
// ========================================
// Route table and registered XGMII crossbar
// Disabled entries send idle, one clk late
// ========================================
`timescale 1ns/1ns
`default_nettype none

module xgmii_switch (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_rxd,
    input  logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_rxc,
    output logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_txd,
    output logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_txc,
    input  logic                                          route_we,
    input  logic [fpga_pkg::CH_W-1:0]                     route_dest,
    input  logic [fpga_pkg::ROUTE_W-1:0]                  route_entry,
    input  logic [fpga_pkg::CH_W-1:0]                     route_rd_dest,
    output logic [fpga_pkg::ROUTE_W-1:0]                  route_rd_entry
);

    localparam int DW = fpga_pkg::XGMII_DW;
    localparam int CW = fpga_pkg::XGMII_CW;

    logic [fpga_pkg::ROUTE_W-1:0] route_tbl [fpga_pkg::CH_CNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < fpga_pkg::CH_CNT; i++) begin
                route_tbl[i] <= '0;
            end
        end else if (route_we) begin
            route_tbl[route_dest] <= route_entry;
        end
    end

    assign route_rd_entry = route_tbl[route_rd_dest];

    for (genvar d = 0; d < fpga_pkg::CH_CNT; d++) begin : g_dest
        logic                       route_en;
        logic [fpga_pkg::CH_W-1:0]  src;

        assign route_en = route_tbl[d][fpga_pkg::ROUTE_W-1];
        assign src      = route_tbl[d][fpga_pkg::CH_W-1:0];

        // Output stage, idle fill when the entry is off
        always_ff @(posedge clk) begin
            if (route_en) begin
                eth_txd[d*DW +: DW] <= eth_rxd[src*DW +: DW];
                eth_txc[d*CW +: CW] <= eth_rxc[src*CW +: CW];
            end else begin
                eth_txd[d*DW +: DW] <= fpga_pkg::XGMII_IDLE_D;
                eth_txc[d*CW +: CW] <= fpga_pkg::XGMII_IDLE_C;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/fpga.sv
// ========================================
// Top level, one clock for all channels
// XGMII and block lock come from outside
// ========================================
`timescale 1ns/1ns
`default_nettype none

module fpga (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          uart_rxd,
    output logic                                          uart_txd,
    input  logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_rxd,
    input  logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_rxc,
    output logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_txd,
    output logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_txc,
    input  logic [fpga_pkg::CH_CNT-1:0]                   rx_block_lock
);

    logic                         rst_sync_n;
    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic [7:0]                   tx_data;
    logic                         tx_valid;
    logic                         tx_credit;
    logic                         route_we;
    logic [fpga_pkg::CH_W-1:0]    route_dest;
    logic [fpga_pkg::ROUTE_W-1:0] route_entry;
    logic [fpga_pkg::CH_W-1:0]    route_rd_dest;
    logic [fpga_pkg::ROUTE_W-1:0] route_rd_entry;

    sync_reset sync_reset_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .rst_sync_n (rst_sync_n)
    );

    uart_rx uart_rx_inst (
        .clk      (clk),
        .rst_n    (rst_sync_n),
        .rxd      (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk       (clk),
        .rst_n     (rst_sync_n),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_credit (tx_credit),
        .txd       (uart_txd)
    );

    cmd_parser cmd_parser_inst (
        .clk            (clk),
        .rst_n          (rst_sync_n),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .tx_data        (tx_data),
        .tx_valid       (tx_valid),
        .tx_credit      (tx_credit),
        .rx_block_lock  (rx_block_lock),
        .route_we       (route_we),
        .route_dest     (route_dest),
        .route_entry    (route_entry),
        .route_rd_dest  (route_rd_dest),
        .route_rd_entry (route_rd_entry)
    );

    xgmii_switch xgmii_switch_inst (
        .clk            (clk),
        .rst_n          (rst_sync_n),
        .eth_rxd        (eth_rxd),
        .eth_rxc        (eth_rxc),
        .eth_txd        (eth_txd),
        .eth_txc        (eth_txc),
        .route_we       (route_we),
        .route_dest     (route_dest),
        .route_entry    (route_entry),
        .route_rd_dest  (route_rd_dest),
        .route_rd_entry (route_rd_entry)
    );

endmodule

`default_nettype wire

// File: tests/tb_fpga.sv
// ========================================
// Testbench for fpga on one shared clock
// Host never sends during a credit wait
// XGMII rx traffic is random
// ========================================
`timescale 1ns/1ns
`default_nettype none

module tb_fpga;

    localparam int RECV_LIMIT = 4000;

    logic clk = 1'b0;
    logic rst_n;
    logic uart_rxd;
    logic uart_txd;
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_rxd;
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_rxc;
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] eth_txd;
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] eth_txc;
    logic [fpga_pkg::CH_CNT-1:0]                   rx_block_lock;

    // Model state and run bookkeeping
    logic [fpga_pkg::ROUTE_W-1:0]                   route_model [fpga_pkg::CH_CNT];
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] rx_hist_d;
    logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] rx_hist_c;
    logic [7:0] cmd_q [$];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];
    logic [7:0] resp;
    logic [7:0] lock_mask;
    integer     seed;
    logic       traffic_on;
    logic       check_en;
    int         check_cnt;
    int         err_cnt;
    int         err_mark;

    fpga dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .uart_rxd      (uart_rxd),
        .uart_txd      (uart_txd),
        .eth_rxd       (eth_rxd),
        .eth_rxc       (eth_rxc),
        .eth_txd       (eth_txd),
        .eth_txc       (eth_txc),
        .rx_block_lock (rx_block_lock)
    );

    always #2 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%0t ns: %s", $time, msg);
        $display("test failed");
        $finish;
    endtask

    task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s got 0x%02h, expected 0x%02h",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_xgmii(input string what,
                               input logic [fpga_pkg::XGMII_DW-1:0] got_d,
                               input logic [fpga_pkg::XGMII_CW-1:0] got_c,
                               input logic [fpga_pkg::XGMII_DW-1:0] exp_d,
                               input logic [fpga_pkg::XGMII_CW-1:0] exp_c);
        check_cnt++;
        if (got_d !== exp_d || got_c !== exp_c) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s got %h/%h, expected %h/%h",
                     $time, what, got_d, got_c, exp_d, exp_c);
        end
    endtask

    // Reference model of one tx channel as {ctrl, data}
    function automatic logic [fpga_pkg::XGMII_CW+fpga_pkg::XGMII_DW-1:0] expected_tx(
        input logic [fpga_pkg::ROUTE_W-1:0]                   entry,
        input logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_DW-1:0] rxd_all,
        input logic [fpga_pkg::CH_CNT*fpga_pkg::XGMII_CW-1:0] rxc_all
    );
        int src;
        src = {29'd0, entry[2:0]};
        if (entry[fpga_pkg::ROUTE_W-1]) begin
            return {rxc_all[src*fpga_pkg::XGMII_CW +: fpga_pkg::XGMII_CW],
                    rxd_all[src*fpga_pkg::XGMII_DW +: fpga_pkg::XGMII_DW]};
        end else begin
            return {fpga_pkg::XGMII_IDLE_C, fpga_pkg::XGMII_IDLE_D};
        end
    endfunction

    function automatic logic [fpga_pkg::XGMII_DW-1:0] rand_data();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    function automatic logic [fpga_pkg::XGMII_CW-1:0] rand_ctrl();
        logic [31:0] r;
        r = $random(seed);
        return r[fpga_pkg::XGMII_CW-1:0];
    endfunction

    task automatic compare_channel(input int d);
        logic [fpga_pkg::XGMII_CW+fpga_pkg::XGMII_DW-1:0] exp_word;
        exp_word = expected_tx(route_model[d], rx_hist_d, rx_hist_c);
        check_xgmii($sformatf("tx channel %0d", d),
                    eth_txd[d*fpga_pkg::XGMII_DW +: fpga_pkg::XGMII_DW],
                    eth_txc[d*fpga_pkg::XGMII_CW +: fpga_pkg::XGMII_CW],
                    exp_word[fpga_pkg::XGMII_DW-1:0],
                    exp_word[fpga_pkg::XGMII_CW+fpga_pkg::XGMII_DW-1:fpga_pkg::XGMII_DW]);
    endtask

    // Random rx traffic on every channel
    always @(posedge clk) begin
        if (traffic_on) begin
            for (int c = 0; c < fpga_pkg::CH_CNT; c++) begin
                eth_rxd[c*fpga_pkg::XGMII_DW +: fpga_pkg::XGMII_DW] <= rand_data();
                eth_rxc[c*fpga_pkg::XGMII_CW +: fpga_pkg::XGMII_CW] <= rand_ctrl();
            end
        end
    end

    // Rx captured here feeds the next negedge's comparison
    always @(negedge clk) begin
        rx_hist_d <= eth_rxd;
        rx_hist_c <= eth_rxc;
        if (check_en) begin
            for (int d = 0; d < fpga_pkg::CH_CNT; d++) begin
                compare_channel(d);
            end
        end
    end

    task automatic uart_send(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            uart_rxd <= frame[i];
            repeat (fpga_pkg::CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    // Samples at negedges near the middle of each bit
    task automatic uart_recv(output logic [7:0] data);
        int         waited;
        logic [7:0] bits;
        waited = 0;
        bits = '0;
        @(negedge clk);
        while (uart_txd !== 1'b0 && waited < RECV_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= RECV_LIMIT) begin
            abort_run("timed out waiting for a start bit on uart_txd");
        end else begin
            repeat (fpga_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);
            if (uart_txd !== 1'b0) begin
                err_cnt++;
                $display("%0t ns: start bit on uart_txd was too short", $time);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (fpga_pkg::CLKS_PER_BIT) @(negedge clk);
                bits[i] = uart_txd;
            end
            repeat (fpga_pkg::CLKS_PER_BIT) @(negedge clk);
            if (uart_txd !== 1'b1) begin
                err_cnt++;
                $display("%0t ns: stop bit missing on uart_txd", $time);
            end
            data = bits;
        end
    endtask

    // One command with its response collected in parallel
    task automatic run_cmd(input logic [7:0] op, input logic [7:0] arg, input bit has_arg,
                           output logic [7:0] answer);
        logic [7:0] rx_byte;
        fork
            begin
                uart_send(op);
                if (has_arg) begin
                    uart_send(arg);
                end
            end
            uart_recv(rx_byte);
        join
        answer = rx_byte;
    endtask

    task automatic set_route(input logic [2:0] dest, input logic [3:0] entry);
        logic [7:0] answer;
        run_cmd(fpga_pkg::OP_SET_ROUTE, {1'b0, dest, entry}, 1'b1, answer);
        check_byte($sformatf("set route %0d", dest), answer, fpga_pkg::RESP_ACK);
        route_model[dest] = entry;
    endtask

    task automatic drive_lock(input logic [7:0] mask);
        @(posedge clk);
        rx_block_lock <= mask;
        lock_mask = mask;
    endtask

    task automatic test_done(input string name, input int err_start);
        $display("%0t ns: %s finished, %0d errors", $time, name, err_cnt - err_start);
    endtask

    initial begin
        seed = 79;
        rst_n = 1'b0;
        uart_rxd = 1'b1;
        eth_rxd = '0;
        eth_rxc = '0;
        rx_block_lock = '0;
        lock_mask = '0;
        traffic_on = 1'b0;
        check_en = 1'b0;
        check_cnt = 0;
        err_cnt = 0;
        for (int d = 0; d < fpga_pkg::CH_CNT; d++) begin
            route_model[d] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        traffic_on <= 1'b1;
        repeat (fpga_pkg::RST_STAGES + 2) @(posedge clk);

        // Idle everywhere while traffic already runs
        err_mark = err_cnt;
        repeat (16) begin
            @(negedge clk);
            for (int d = 0; d < fpga_pkg::CH_CNT; d++) begin
                check_xgmii($sformatf("idle channel %0d", d),
                            eth_txd[d*fpga_pkg::XGMII_DW +: fpga_pkg::XGMII_DW],
                            eth_txc[d*fpga_pkg::XGMII_CW +: fpga_pkg::XGMII_CW],
                            fpga_pkg::XGMII_IDLE_D, fpga_pkg::XGMII_IDLE_C);
            end
            check_level("uart_txd idle", uart_txd, 1'b1);
        end
        test_done("idle after reset", err_mark);

        err_mark = err_cnt;
        set_route(3'd0, 4'hd);
        set_route(3'd1, 4'h8);
        set_route(3'd3, 4'hb);
        set_route(3'd6, 4'hf);
        set_route(3'd7, 4'ha);
        @(posedge clk);
        check_en = 1'b1;
        repeat (64) @(posedge clk);
        test_done("route setup and forwarding", err_mark);

        err_mark = err_cnt;
        for (int d = 0; d < fpga_pkg::CH_CNT; d++) begin
            run_cmd(fpga_pkg::OP_GET_ROUTE, 8'(d), 1'b1, resp);
            check_byte($sformatf("get route %0d", d), resp, {4'b0000, route_model[d]});
        end
        test_done("route readback", err_mark);

        err_mark = err_cnt;
        drive_lock(8'h5a);
        run_cmd(fpga_pkg::OP_GET_LOCK, 8'h00, 1'b0, resp);
        check_byte("lock mask", resp, lock_mask);
        drive_lock(8'hc3);
        run_cmd(fpga_pkg::OP_GET_LOCK, 8'h00, 1'b0, resp);
        check_byte("lock mask", resp, lock_mask);
        test_done("block lock readback", err_mark);

        err_mark = err_cnt;
        run_cmd(8'h7e, 8'h00, 1'b0, resp);
        check_byte("unknown opcode", resp, fpga_pkg::RESP_ERR);
        check_en = 1'b0;
        set_route(3'd3, 4'h3);
        @(posedge clk);
        check_en = 1'b1;
        repeat (64) @(posedge clk);
        test_done("error and disable", err_mark);

        // Six commands in a row with responses in order
        err_mark = err_cnt;
        check_en = 1'b0;
        route_model[2] = 4'h9;
        cmd_q = '{8'h03, 8'h01, 8'h29, 8'h02, 8'h02, 8'h55, 8'h03, 8'h02, 8'h06};
        exp_q = '{lock_mask, fpga_pkg::RESP_ACK, {4'b0000, route_model[2]},
                  fpga_pkg::RESP_ERR, lock_mask, {4'b0000, route_model[6]}};
        fork
            begin
                foreach (cmd_q[i]) begin
                    uart_send(cmd_q[i]);
                end
            end
            begin
                for (int i = 0; i < exp_q.size(); i++) begin
                    uart_recv(resp);
                    got_q.push_back(resp);
                end
            end
        join
        foreach (exp_q[i]) begin
            check_byte($sformatf("burst response %0d", i), got_q[i], exp_q[i]);
        end
        @(posedge clk);
        check_en = 1'b1;
        repeat (32) @(posedge clk);
        test_done("back-to-back commands", err_mark);

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/fpga_pkg.sv
hdl/sync_reset.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_parser.sv
hdl/xgmii_switch.sv
hdl/fpga.sv
tests/tb_fpga.sv

// File: Makefile
TOP := tb_fpga

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o V$(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
